// ==== sources.f ====
rtl/debug_pkg.sv
rtl/host_if.sv
rtl/host_port.sv
rtl/program_loader.sv
rtl/debug_controller.sv
rtl/debug_unit.sv
verif/host_uart_model.sv
verif/tb_debug_unit.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_debug_unit
RTL_TOP    = debug_unit
FILELIST   = sources.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/tb_debug_unit.sv ====
`timescale 1ns/1ps

module tb_debug_unit;
    import debug_pkg::*;

    localparam int addr_w  = 11;
    localparam int word_w  = 32;
    localparam int n_tests = 4;

    typedef struct {
        logic [7:0] idle_byte; // junk sent before the start byte
        int         n_words;
        logic [7:0] command;
        int         n_steps;
        logic [7:0] report;    // last report byte expected
    } scenario_t;

    logic              clk;
    logic              reset;
    logic              halt;
    logic [byte_w-1:0] pc_byte;
    logic              rx_done_tick;
    logic [byte_w-1:0] rx_byte;
    logic              tx_done_tick;
    logic              tx_start;
    logic [byte_w-1:0] tx_byte;
    logic [addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_data;
    logic              mem_wr;
    logic              cpu_run;
    logic              loading;

    scenario_t         scenarios [n_tests];
    logic [word_w-1:0] exp_words [64];
    logic [31:0]       lfsr_state;
    int                errors;
    int                checks;
    int                cycle_count;
    int                cycle_limit;
    int                errors_before;

    debug_unit #(.addr_w(addr_w), .word_w(word_w)) debug_unit_inst (
        .clk(clk), .reset(reset), .halt(halt), .pc_byte(pc_byte),
        .rx_done_tick(rx_done_tick), .rx_byte(rx_byte), .tx_done_tick(tx_done_tick),
        .tx_start(tx_start), .tx_byte(tx_byte), .mem_addr(mem_addr),
        .mem_data(mem_data), .mem_wr(mem_wr), .cpu_run(cpu_run), .loading(loading)
    );

    host_uart_model #(.addr_w(addr_w), .word_w(word_w)) uart (
        .clk(clk), .reset(reset), .loading(loading), .cpu_run(cpu_run),
        .mem_addr(mem_addr), .mem_data(mem_data), .mem_wr(mem_wr), .tx_start(tx_start),
        .rx_done_tick(rx_done_tick), .rx_byte(rx_byte), .tx_done_tick(tx_done_tick),
        .halt(halt), .pc_byte(pc_byte)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond)
        else
        begin
            $display("FAILED at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [byte_w-1:0] random_byte();
        logic [byte_w-1:0] b;
        for (int k = 0; k < byte_w; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state); // one step per bit
            b[k] = lfsr_state[0];
        end
        return b;
    endfunction

    task automatic load_program(input int n);
        logic [word_w-1:0] w;
        uart.halt_pc = n - 1;
        uart.send_byte(cmd_start);
        for (int i = 0; i < n; i++)
        begin
            for (int k = 0; k < word_w / byte_w; k++)
                w[k*byte_w +: byte_w] = random_byte();
            if (i == n - 1)
                w[word_w-1 -: halt_opcode_w] = '1; // halt word ends the load
            else if (&w[word_w-1 -: halt_opcode_w])
                w[word_w-1] = 1'b0;
            exp_words[i] = w;
            for (int k = 0; k < word_w / byte_w; k++)
                uart.send_byte(w[k*byte_w +: byte_w]); // LSB first
        end
        repeat (3) @(negedge clk);
        expect_true(uart.wr_addr.size() == n,
            $sformatf("%0d writes, expected %0d", uart.wr_addr.size(), n));
        for (int i = 0; i < uart.wr_addr.size() && i < n; i++)
            expect_true(int'(uart.wr_addr[i]) == i && uart.wr_data[i] == exp_words[i]
                && uart.wr_loading[i], $sformatf("write %0d at %0d data %h, expected %h",
                i, uart.wr_addr[i], uart.wr_data[i], exp_words[i]));
        expect_true(!loading, "loading still high after the halt word");
    endtask

    task automatic await_report(input logic [7:0] pc_expect, input int runs_expect);
        int   writes;
        logic dropped;
        writes = uart.wr_addr.size();
        while (!tx_start)
            @(negedge clk);
        expect_true(uart.run_cycles == runs_expect, $sformatf("core ran %0d cycles, expected %0d",
            uart.run_cycles, runs_expect));
        expect_true(tx_byte == pc_expect, $sformatf("report %h, expected %h", tx_byte, pc_expect));
        uart.send_byte(cmd_step); // lands while the report is open
        expect_true(tx_start, "tx_start dropped before tx_done_tick");
        uart.finish_tx(dropped);
        expect_true(dropped, "tx_start still high after tx_done_tick rose");
        repeat (3) @(negedge clk);
        expect_true(uart.tx_count == 1, $sformatf("%0d reports, expected 1", uart.tx_count));
        expect_true(uart.run_cycles == runs_expect && uart.wr_addr.size() == writes,
            "byte received during the send reached the core or the memory");
    endtask

    task automatic run_scenario(input scenario_t sc);
        logic [7:0] pc_expect;
        uart.clear_capture();
        uart.send_byte(sc.idle_byte);
        repeat (2) @(negedge clk);
        expect_true(uart.wr_addr.size() == 0 && !loading, "non-start byte left idle");
        load_program(sc.n_words);
        uart.clear_counters();
        uart.send_byte(sc.command);
        if (sc.command == cmd_continuous)
            await_report(sc.report, sc.n_words - 1);
        else if (sc.command == cmd_step_mode)
        begin
            for (int k = 1; k <= sc.n_steps; k++)
            begin
                pc_expect = (k == sc.n_steps) ? sc.report : 8'(k);
                uart.clear_counters();
                uart.send_byte(cmd_step);
                await_report(pc_expect, 1);
                uart.clear_counters();
                uart.send_byte(cmd_continuous); // not a step command
                repeat (4) @(negedge clk);
                expect_true(uart.run_cycles == 0 && uart.tx_count == 0,
                    "ignored byte in step mode started the core");
            end
            uart.send_byte(cmd_reprogram);
        end
        else
        begin
            repeat (4) @(negedge clk);
            expect_true(uart.run_cycles == 0 && uart.tx_count == 0,
                "unknown command started a run");
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        lfsr_state  = 32'h1d4ce866;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        scenarios[0] = '{8'h07, 4, cmd_continuous, 0, 8'd3};
        scenarios[1] = '{8'h06, 3, cmd_step_mode, 3, 8'd3};
        scenarios[2] = '{8'h02, 2, 8'h09, 0, 8'd0}; // unknown command
        scenarios[3] = '{8'h03, 6, cmd_continuous, 0, 8'd5};
        cycle_limit = 200;
        for (int t = 0; t < n_tests; t++)
            cycle_limit += 2 * (3 * (4 + 4 * scenarios[t].n_words + 2 * scenarios[t].n_steps)
                + (scenarios[t].n_steps + 1) * (scenarios[t].n_words + 20));
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < n_tests; t++)
        begin
            errors_before = errors;
            run_scenario(scenarios[t]);
            if (errors == errors_before)
                $display("test %0d passed", t);
            else
                $display("test %0d failed with %0d errors", t, errors - errors_before);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== verif/host_uart_model.sv ====
`timescale 1ns/1ps

module host_uart_model #(
    parameter int addr_w = 11,
    parameter int word_w = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         loading,
    input  logic                         cpu_run,
    input  logic [addr_w-1:0]            mem_addr,
    input  logic [word_w-1:0]            mem_data,
    input  logic                         mem_wr,
    input  logic                         tx_start,
    output logic                         rx_done_tick,
    output logic [debug_pkg::byte_w-1:0] rx_byte,
    output logic                         tx_done_tick,
    output logic                         halt,
    output logic [debug_pkg::byte_w-1:0] pc_byte
);
    import debug_pkg::*;

    logic [byte_w-1:0] pc;      // core PC, one step per run cycle
    int                halt_pc; // PC at which the core halts
    int                run_cycles;
    int                tx_count;
    logic              tx_start_q;

    logic [addr_w-1:0] wr_addr[$]; // captured memory writes
    logic [word_w-1:0] wr_data[$];
    logic              wr_loading[$];

    initial
    begin
        rx_done_tick = 1'b0;
        rx_byte      = '0;
        tx_done_tick = 1'b0;
        halt         = 1'b0;
        pc           = '0;
        halt_pc      = 0;
        run_cycles   = 0;
        tx_count     = 0;
        tx_start_q   = 1'b0;
    end

    assign pc_byte = pc;

    //////////////////////////////
    // core stand-in
    //////////////////////////////

    always @(negedge clk)
    begin
        if (reset || loading)
        begin
            pc   <= '0;
            halt <= 1'b0;
        end
        else if (cpu_run && !halt)
        begin
            pc   <= pc + 8'd1;
            halt <= (int'(pc) + 1 == halt_pc); // halt word reached
        end
        else if (!cpu_run)
            halt <= 1'b0;
    end

    // memory and transmit monitor
    always @(negedge clk)
    begin
        if (cpu_run)
            run_cycles++;
        if (mem_wr)
        begin
            wr_addr.push_back(mem_addr);
            wr_data.push_back(mem_data);
            wr_loading.push_back(loading);
        end
        if (tx_start && !tx_start_q)
            tx_count++; // count each new report
        tx_start_q <= tx_start;
    end

    //////////////////////////////
    // host side
    //////////////////////////////

    // done tick held two cycles, then low for one
    task automatic send_byte(input logic [byte_w-1:0] b);
        @(negedge clk);
        rx_byte      = b;
        rx_done_tick = 1'b1;
        repeat (2) @(negedge clk);
        rx_done_tick = 1'b0;
    endtask

    task automatic finish_tx(output logic dropped);
        @(negedge clk);
        tx_done_tick = 1'b1;
        @(negedge clk);
        dropped = !tx_start; // request gone one cycle after the rise
        @(negedge clk);
        tx_done_tick = 1'b0;
    endtask

    task automatic clear_capture();
        wr_addr.delete();
        wr_data.delete();
        wr_loading.delete();
    endtask

    task automatic clear_counters();
        run_cycles = 0;
        tx_count   = 0;
    endtask

endmodule

// ==== rtl/debug_unit.sv ====
`timescale 1ns/1ps

module debug_unit #(
    parameter int addr_w = 11,
    parameter int word_w = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         halt,
    input  logic [debug_pkg::byte_w-1:0] pc_byte,
    input  logic                         rx_done_tick,
    input  logic [debug_pkg::byte_w-1:0] rx_byte,
    input  logic                         tx_done_tick,
    output logic                         tx_start,
    output logic [debug_pkg::byte_w-1:0] tx_byte,
    output logic [addr_w-1:0]            mem_addr,
    output logic [word_w-1:0]            mem_data,
    output logic                         mem_wr,
    output logic                         cpu_run,
    output logic                         loading
);

    logic load_active; // controller in the loading state
    logic load_done;   // halt word written

    host_if host_bus ();

    // UART handshake
    host_port host_port_inst (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_byte      (rx_byte),
        .tx_done_tick (tx_done_tick),
        .pc_byte      (pc_byte),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .host         (host_bus.port)
    );

    program_loader #(
        .addr_w (addr_w),
        .word_w (word_w)
    ) program_loader_inst (
        .clk         (clk),
        .reset       (reset),
        .host        (host_bus.loader),
        .load_active (load_active),
        .load_done   (load_done),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_wr      (mem_wr)
    );

    debug_controller debug_controller_inst (
        .clk         (clk),
        .reset       (reset),
        .host        (host_bus.ctrl),
        .halt        (halt),
        .load_done   (load_done),
        .load_active (load_active),
        .loading     (loading),
        .cpu_run     (cpu_run)
    );

endmodule

// ==== rtl/debug_controller.sv ====
`timescale 1ns/1ps

module debug_controller (
    input  logic clk,
    input  logic reset,
    host_if.ctrl host,
    input  logic halt,
    input  logic load_done,
    output logic load_active,
    output logic loading,
    output logic cpu_run
);
    import debug_pkg::*;

    debug_state_e state;
    debug_state_e state_next;

    logic run_pulse;      // single core cycle in step mode
    logic run_pulse_next;
    logic from_step;      // where sending returns to
    logic send_req_q;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= idle;
            run_pulse  <= 1'b0;
            from_step  <= 1'b0;
            send_req_q <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            run_pulse <= run_pulse_next;
            // one request, in the first cycle of sending
            send_req_q <= (state_next == sending) && (state != sending);
            if (state != sending)
                from_step <= (state == stepping);
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    // the port named loading hides the state of the same name
    always_comb
    begin
        state_next     = state;
        run_pulse_next = 1'b0;
        case (state)
            idle:
                if (host.rx_valid && host.rx_byte == cmd_start)
                    state_next = debug_pkg::loading;
            debug_pkg::loading:
                if (load_done)
                    state_next = waiting;
            waiting:
                if (host.rx_valid)
                begin
                    case (host.rx_byte)
                        cmd_continuous: state_next = running;
                        cmd_step_mode:  state_next = stepping;
                        default:        state_next = idle; // reprogram or junk
                    endcase
                end
            stepping:
                if (run_pulse)
                    state_next = sending; // core has stepped, report its PC
                else if (host.rx_valid)
                begin
                    if (host.rx_byte == cmd_step)
                        run_pulse_next = 1'b1;
                    else if (host.rx_byte == cmd_reprogram)
                        state_next = idle;
                end
            running:
                if (halt)
                    state_next = sending;
            sending:
                if (host.send_done)
                    state_next = from_step ? stepping : idle;
            default:
                state_next = idle;
        endcase
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    assign load_active   = (state == debug_pkg::loading);
    assign loading       = load_active; // tells the core memory is busy
    assign cpu_run       = (state == running) || run_pulse;
    assign host.send_req = send_req_q;

endmodule

// ==== rtl/program_loader.sv ====
`timescale 1ns/1ps

module program_loader #(
    parameter int addr_w = 11,
    parameter int word_w = 32
) (
    input  logic              clk,
    input  logic              reset,
    host_if.loader            host,
    input  logic              load_active,
    output logic              load_done,
    output logic [addr_w-1:0] mem_addr,
    output logic [word_w-1:0] mem_data,
    output logic              mem_wr
);
    import debug_pkg::*;

    localparam int bytes_per_word = word_w / byte_w;
    localparam int cnt_w = (bytes_per_word > 1) ? $clog2(bytes_per_word) : 1;
    localparam logic [cnt_w-1:0] last_byte = cnt_w'(bytes_per_word - 1);

    logic [cnt_w-1:0]  byte_cnt; // bytes of the current word so far
    logic [word_w-1:0] word_q;
    logic              byte_in;
    logic              word_done;

    assign byte_in   = host.rx_valid && load_active;
    assign word_done = byte_in && (byte_cnt == last_byte);

    //////////////////////////////
    // word assembly
    //////////////////////////////

    // bytes arrive LSB first, so each one enters at the top and
    // the first byte has reached bit 0 once the word is complete
    always_ff @(posedge clk)
    begin
        if (byte_in)
            word_q <= {host.rx_byte, word_q[word_w-1:byte_w]};
    end

    //////////////////////////////
    // memory write
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !load_active)
        begin
            byte_cnt <= '0; // every load starts at address 0
            mem_addr <= '0;
            mem_wr   <= 1'b0;
        end
        else
        begin
            mem_wr <= word_done; // write the cycle after the last byte
            if (byte_in)
            begin
                if (byte_cnt == last_byte)
                    byte_cnt <= '0;
                else
                    byte_cnt <= byte_cnt + 1'b1;
            end
            if (mem_wr)
                mem_addr <= mem_addr + 1'b1; // next slot after each write
        end
    end

    assign mem_data = word_q; // stable while mem_wr is high

    // halt opcode in the word being written ends the load
    assign load_done = mem_wr && (&word_q[word_w-1 -: halt_opcode_w]);

endmodule

// ==== rtl/host_port.sv ====
`timescale 1ns/1ps

module host_port (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rx_done_tick,
    input  logic [debug_pkg::byte_w-1:0] rx_byte,
    input  logic                         tx_done_tick,
    input  logic [debug_pkg::byte_w-1:0] pc_byte,
    output logic                         tx_start,
    output logic [debug_pkg::byte_w-1:0] tx_byte,
    host_if.port                         host
);

    logic rx_done_q; // previous value of the rx tick
    logic tx_done_q;
    logic tx_rise;

    //////////////////////////////
    // edge detection
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_done_q <= 1'b0;
            tx_done_q <= 1'b0;
        end
        else
        begin
            rx_done_q <= rx_done_tick;
            tx_done_q <= tx_done_tick;
        end
    end

    // the UART may hold done for several cycles, count the rise only
    assign host.rx_valid = rx_done_tick && !rx_done_q;
    assign host.rx_byte  = rx_byte;
    assign tx_rise       = tx_done_tick && !tx_done_q;

    //////////////////////////////
    // transmit request
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            tx_start <= 1'b0;
        else if (host.send_req)
            tx_start <= 1'b1;
        else if (tx_rise)
            tx_start <= 1'b0; // UART done, drop next cycle
    end

    always_ff @(posedge clk)
    begin
        if (host.send_req)
            tx_byte <= pc_byte; // low byte of the PC
    end

    // a done rise outside an open send is not ours
    assign host.send_done = tx_start && tx_rise;

endmodule

// ==== rtl/host_if.sv ====
`timescale 1ns/1ps

interface host_if;
    import debug_pkg::*;

    logic              rx_valid;  // one cycle per received byte
    logic [byte_w-1:0] rx_byte;
    logic              send_req;  // report requested
    logic              send_done; // UART finished the report

    // UART side, owns the receive path and the transmit handshake
    modport port (
        output rx_valid,
        output rx_byte,
        input  send_req,
        output send_done
    );

    modport ctrl (
        input  rx_valid,
        input  rx_byte,
        output send_req,
        input  send_done
    );

    // loader only listens
    modport loader (
        input rx_valid,
        input rx_byte
    );

endinterface

// ==== rtl/debug_pkg.sv ====
package debug_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int byte_w = 8; // one UART character

    // top instruction bits that mark the halt word when all ones
    localparam int halt_opcode_w = 6;

    //////////////////////////////
    // mode FSM
    //////////////////////////////

    typedef enum logic [2:0] {
        idle     = 3'd0, // waiting for a start byte
        loading  = 3'd1, // program bytes go to instruction memory
        waiting  = 3'd2, // program loaded, expecting a command
        stepping = 3'd3, // one core cycle per step byte
        running  = 3'd4, // core free running until halt
        sending  = 3'd5  // report byte in flight
    } debug_state_e;

    //////////////////////////////
    // host command bytes
    //////////////////////////////

    typedef enum logic [7:0] {
        cmd_start      = 8'h01,
        cmd_continuous = 8'h02,
        cmd_step_mode  = 8'h03,
        cmd_reprogram  = 8'h05,
        cmd_step       = 8'h06
    } host_cmd_e;

endpackage
